// File: logic/ahb_addr_decoder.sv
// AHB-Lite address decoder
module ahb_addr_decoder #(
  parameter int MASTERS = 3,
  parameter int SLAVES  = 3,
  parameter int PLEN    = 32
) (
  input  logic [MASTERS-1:0]                             mst_hsel,
  input  logic [MASTERS-1:0][PLEN-1:0]                   mst_haddr,
  input  logic [MASTERS-1:0][ahb_lite_pkg::htrans_w-1:0] mst_htrans,
  input  logic [MASTERS-1:0]                             mst_hmastlock,
  output logic [MASTERS-1:0][SLAVES-1:0]                 req_sel,
  output logic [MASTERS-1:0]                             can_switch,
  output logic [MASTERS-1:0]                             unmapped
);
  import ahb_lite_pkg::*;
  import switch_map_pkg::*;

  ////////////////////////////////////////////////////////////
  // Per-master decode
  ////////////////////////////////////////////////////////////

  // Region field of each master address
  logic [MASTERS-1:0][region_bits-1:0] region;
  // Selected and not IDLE
  logic [MASTERS-1:0]                  valid;

  genvar m, s;

  for (m = 0; m < MASTERS; m++) begin : g_mst
    assign region[m] = mst_haddr[m][PLEN-1 -: region_bits];

    // BUSY counts as valid, it keeps the slave port owned
    assign valid[m] = mst_hsel[m] && (mst_htrans[m] != htrans_idle);

    // One compare per slave region
    for (s = 0; s < SLAVES; s++) begin : g_slv
      localparam logic [PLEN-1:0] base = PLEN'(region_base(s, PLEN));

      assign req_sel[m][s] = valid[m] && (region[m] == base[PLEN-1 -: region_bits]);
    end

    // Valid transfer that hits no slave region
    assign unmapped[m] = valid[m] && !(|req_sel[m]);

    // Owner may be replaced outside locked sequences and burst continuations
    assign can_switch[m] = !mst_hmastlock[m] &&
                           (mst_htrans[m] != htrans_seq) &&
                           (mst_htrans[m] != htrans_busy);
  end

endmodule

// File: logic/ahb_lite_pkg.sv
// AHB-Lite protocol definitions
package ahb_lite_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  // Transfer size, HSIZE
  localparam int hsize_w  = 3;
  // Burst type, HBURST
  localparam int hburst_w = 3;
  // Protection control, HPROT
  localparam int hprot_w  = 4;
  // Transfer type, HTRANS
  localparam int htrans_w = 2;

  ////////////////////////////////////////////////////////////
  // Transfer type encodings
  ////////////////////////////////////////////////////////////

  // No transfer wanted, slave answers OKAY with zero wait
  localparam logic [htrans_w-1:0] htrans_idle   = 2'b00;
  // Master inserts a gap inside a burst
  localparam logic [htrans_w-1:0] htrans_busy   = 2'b01;
  // First beat of a burst or a single transfer
  localparam logic [htrans_w-1:0] htrans_nonseq = 2'b10;
  // Remaining beats of a burst
  localparam logic [htrans_w-1:0] htrans_seq    = 2'b11;

  ////////////////////////////////////////////////////////////
  // Response encodings
  ////////////////////////////////////////////////////////////

  // Transfer completed
  localparam logic hresp_okay  = 1'b0;
  // Two-cycle error response
  localparam logic hresp_error = 1'b1;

endpackage

// File: logic/ahb_response_router.sv
// AHB-Lite response router
module ahb_response_router #(
  parameter int MASTERS = 3,
  parameter int SLAVES  = 3,
  parameter int XLEN    = 32
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,

  // Decode and grant state
  input  logic [MASTERS-1:0][SLAVES-1:0]  req_sel,
  input  logic [MASTERS-1:0]              unmapped,
  input  logic [SLAVES-1:0][MASTERS-1:0]  granted_master,

  // Slave responses
  input  logic [SLAVES-1:0][XLEN-1:0]     slv_hrdata,
  input  logic [SLAVES-1:0]               slv_hready,
  input  logic [SLAVES-1:0]               slv_hresp,

  // Master responses
  output logic [MASTERS-1:0][XLEN-1:0]    mst_hrdata,
  output logic [MASTERS-1:0]              mst_hreadyout,
  output logic [MASTERS-1:0]              mst_hresp
);
  import ahb_lite_pkg::*;

  localparam int sidx_w = (SLAVES > 1) ? $clog2(SLAVES) : 1;

  genvar m;

  for (m = 0; m < MASTERS; m++) begin : g_mst
    // Requested slave in the address phase
    logic [sidx_w-1:0] req_idx;
    logic              req_any;
    logic              addr_ok;
    // Slave that owns the data phase
    logic [sidx_w-1:0] dp_idx;
    logic              dp_busy;
    logic              dp_ready;
    logic              slave_done;
    // Data phase finished at the slave while the master was stalled
    logic              dp_held;
    logic [XLEN-1:0]   held_rdata;
    logic              held_resp;
    // Two-cycle ERROR for unmapped addresses
    logic              err_first;
    logic              err_last;

    ////////////////////////////////////////////////////////////
    // Address phase
    ////////////////////////////////////////////////////////////

    // Regions are disjoint, at most one bit set
    always_comb begin
      req_idx = '0;
      for (int s = 0; s < SLAVES; s++) begin
        if (req_sel[m][s]) begin
          req_idx = sidx_w'(s);
        end
      end
    end

    assign req_any = |req_sel[m];

    // Stall until granted and the slave can take a new address
    assign addr_ok = !req_any || (granted_master[req_idx][m] && slv_hready[req_idx]);

    ////////////////////////////////////////////////////////////
    // Data phase
    ////////////////////////////////////////////////////////////

    assign slave_done = dp_busy && !dp_held && slv_hready[dp_idx];

    always_comb begin
      if (err_first) begin
        dp_ready = 1'b0;
      end else if (err_last || dp_held || !dp_busy) begin
        dp_ready = 1'b1;
      end else begin
        dp_ready = slv_hready[dp_idx];
      end
    end

    assign mst_hreadyout[m] = dp_ready && addr_ok;

    assign mst_hrdata[m] = dp_held ? held_rdata : slv_hrdata[dp_idx];

    assign mst_hresp[m] = (err_first || err_last) ? hresp_error :
                          dp_held                 ? held_resp   :
                          dp_busy                 ? slv_hresp[dp_idx] :
                                                    hresp_okay;

    // New data phase on every accepted address phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
        dp_busy   <= 1'b0;
        dp_idx    <= '0;
        dp_held   <= 1'b0;
        err_first <= 1'b0;
        err_last  <= 1'b0;
      end else if (mst_hreadyout[m]) begin
        dp_busy   <= req_any;
        dp_idx    <= req_idx;
        dp_held   <= 1'b0;
        err_first <= unmapped[m];
        err_last  <= 1'b0;
      end else begin
        // ERROR moves from ready low to ready high
        if (err_first) begin
          err_first <= 1'b0;
          err_last  <= 1'b1;
        end
        if (slave_done) begin
          dp_held <= 1'b1;
        end
      end
    end

    // Capture the response the master has not seen yet
    always_ff @(posedge HCLK) begin
      if (!mst_hreadyout[m] && slave_done) begin
        held_rdata <= slv_hrdata[dp_idx];
        held_resp  <= slv_hresp[dp_idx];
      end
    end
  end

endmodule

// File: logic/ahb_slave_port.sv
// AHB-Lite slave port arbiter
module ahb_slave_port #(
  parameter int MASTERS = 3,
  parameter int PLEN    = 32,
  parameter int XLEN    = 32
) (
  input  logic                                           HCLK,
  input  logic                                           HRESETn,

  // Requests and priorities of all masters
  input  logic [MASTERS-1:0]                             req_sel_col,
  input  logic [MASTERS-1:0][switch_map_pkg::prio_w-1:0] mst_priority,

  // Address and write-data phases of all masters
  input  logic [MASTERS-1:0][PLEN-1:0]                   mst_haddr,
  input  logic [MASTERS-1:0][XLEN-1:0]                   mst_hwdata,
  input  logic [MASTERS-1:0]                             mst_hwrite,
  input  logic [MASTERS-1:0][ahb_lite_pkg::hsize_w-1:0]  mst_hsize,
  input  logic [MASTERS-1:0][ahb_lite_pkg::hburst_w-1:0] mst_hburst,
  input  logic [MASTERS-1:0][ahb_lite_pkg::hprot_w-1:0]  mst_hprot,
  input  logic [MASTERS-1:0][ahb_lite_pkg::htrans_w-1:0] mst_htrans,
  input  logic [MASTERS-1:0]                             mst_hmastlock,
  input  logic [MASTERS-1:0]                             can_switch,
  input  logic                                           slv_hready,

  // Layer toward the slave
  output logic                                           slv_hsel,
  output logic [PLEN-1:0]                                slv_haddr,
  output logic [XLEN-1:0]                                slv_hwdata,
  output logic                                           slv_hwrite,
  output logic [ahb_lite_pkg::hsize_w-1:0]               slv_hsize,
  output logic [ahb_lite_pkg::hburst_w-1:0]              slv_hburst,
  output logic [ahb_lite_pkg::hprot_w-1:0]               slv_hprot,
  output logic [ahb_lite_pkg::htrans_w-1:0]              slv_htrans,
  output logic                                           slv_hmastlock,
  output logic [MASTERS-1:0]                             granted_master
);
  import ahb_lite_pkg::*;
  import switch_map_pkg::*;

  localparam int midx_w = (MASTERS > 1) ? $clog2(MASTERS) : 1;

  // Highest requested level and its requesters
  logic [prio_w-1:0]   top_prio;
  logic [MASTERS-1:0]  top_req;
  logic                has_req;
  // Last master granted at each level
  logic [midx_w-1:0]   last_idx [prio_levels];
  // Address owner, next owner, write-data owner
  logic [midx_w-1:0]   grant_idx;
  logic [midx_w-1:0]   next_idx;
  logic [midx_w-1:0]   wdata_idx;
  logic                owner_switch;
  logic                grant_move;
  // Owner already has an accepted beat on this layer
  logic                burst_open;
  logic [htrans_w-1:0] owner_htrans;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // Highest priority among requesters
  always_comb begin
    top_prio = '0;
    for (int n = 0; n < MASTERS; n++) begin
      if (req_sel_col[n] && (mst_priority[n] > top_prio)) begin
        top_prio = mst_priority[n];
      end
    end
  end

  // Requesters at that level only
  always_comb begin
    for (int n = 0; n < MASTERS; n++) begin
      top_req[n] = req_sel_col[n] && (mst_priority[n] == top_prio);
    end
  end

  assign has_req = |top_req;

  // Round-robin search, starting after the last grant at this level
  // Scan runs backwards so the nearest candidate is written last
  always_comb begin : rr_search
    int cand;
    next_idx = grant_idx;
    for (int n = MASTERS; n >= 1; n--) begin
      cand = int'(last_idx[top_prio]) + n;
      if (cand >= MASTERS) begin
        cand = cand - MASTERS;
      end
      if (top_req[cand]) begin
        next_idx = midx_w'(cand);
      end
    end
  end

  // One-hot grant to index
  always_comb begin
    grant_idx = '0;
    for (int n = 0; n < MASTERS; n++) begin
      if (granted_master[n]) begin
        grant_idx = midx_w'(n);
      end
    end
  end

  // Grant frozen while the slave stalls or the owner is mid-burst
  assign owner_switch = slv_hready && can_switch[grant_idx];
  assign grant_move   = owner_switch && has_req && (next_idx != grant_idx);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      granted_master <= MASTERS'(1);
      for (int l = 0; l < prio_levels; l++) begin
        last_idx[l] <= '0;
      end
    end else if (owner_switch && has_req) begin
      granted_master      <= MASTERS'(1) << next_idx;
      last_idx[top_prio]  <= next_idx;
    end
  end

  // Write data belongs to the owner of the last accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wdata_idx <= '0;
    end else if (slv_hready) begin
      wdata_idx <= grant_idx;
    end
  end

  // Burst tracking, cleared when the layer changes hands
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_open <= 1'b0;
    end else if (slv_hready) begin
      if (grant_move) begin
        burst_open <= 1'b0;
      end else begin
        burst_open <= slv_hsel && (slv_htrans != htrans_idle);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and data multiplexer
  ////////////////////////////////////////////////////////////

  // Owner only selects this slave when its address hits this region
  assign slv_hsel     = req_sel_col[grant_idx];
  assign owner_htrans = mst_htrans[grant_idx];

  // A burst entering mid-way starts as NONSEQ on this layer
  always_comb begin
    slv_htrans = owner_htrans;
    if (!slv_hsel) begin
      slv_htrans = htrans_idle;
    end else if (!burst_open && (owner_htrans == htrans_seq)) begin
      slv_htrans = htrans_nonseq;
    end
  end

  assign slv_haddr     = mst_haddr[grant_idx];
  assign slv_hwrite    = mst_hwrite[grant_idx];
  assign slv_hsize     = mst_hsize[grant_idx];
  assign slv_hburst    = mst_hburst[grant_idx];
  assign slv_hprot     = mst_hprot[grant_idx];
  assign slv_hmastlock = mst_hmastlock[grant_idx];
  assign slv_hwdata    = mst_hwdata[wdata_idx];

endmodule

// File: logic/ahb_switch_top.sv
// AHB-Lite multi-layer switch
module ahb_switch_top #(
  parameter int MASTERS = 3,
  parameter int SLAVES  = 3,
  parameter int PLEN    = 32,
  parameter int XLEN    = 32
) (
  input  logic                                           HCLK,
  input  logic                                           HRESETn,

  // Master side
  input  logic [MASTERS-1:0]                             mst_hsel,
  input  logic [MASTERS-1:0][PLEN-1:0]                   mst_haddr,
  input  logic [MASTERS-1:0][XLEN-1:0]                   mst_hwdata,
  input  logic [MASTERS-1:0]                             mst_hwrite,
  input  logic [MASTERS-1:0][ahb_lite_pkg::hsize_w-1:0]  mst_hsize,
  input  logic [MASTERS-1:0][ahb_lite_pkg::hburst_w-1:0] mst_hburst,
  input  logic [MASTERS-1:0][ahb_lite_pkg::hprot_w-1:0]  mst_hprot,
  input  logic [MASTERS-1:0][ahb_lite_pkg::htrans_w-1:0] mst_htrans,
  input  logic [MASTERS-1:0]                             mst_hmastlock,
  input  logic [MASTERS-1:0][switch_map_pkg::prio_w-1:0] mst_priority,
  output logic [MASTERS-1:0][XLEN-1:0]                   mst_hrdata,
  output logic [MASTERS-1:0]                             mst_hreadyout,
  output logic [MASTERS-1:0]                             mst_hresp,

  // Slave side
  output logic [SLAVES-1:0]                              slv_hsel,
  output logic [SLAVES-1:0][PLEN-1:0]                    slv_haddr,
  output logic [SLAVES-1:0][XLEN-1:0]                    slv_hwdata,
  output logic [SLAVES-1:0]                              slv_hwrite,
  output logic [SLAVES-1:0][ahb_lite_pkg::hsize_w-1:0]   slv_hsize,
  output logic [SLAVES-1:0][ahb_lite_pkg::hburst_w-1:0]  slv_hburst,
  output logic [SLAVES-1:0][ahb_lite_pkg::hprot_w-1:0]   slv_hprot,
  output logic [SLAVES-1:0][ahb_lite_pkg::htrans_w-1:0]  slv_htrans,
  output logic [SLAVES-1:0]                              slv_hmastlock,
  input  logic [SLAVES-1:0][XLEN-1:0]                    slv_hrdata,
  input  logic [SLAVES-1:0]                              slv_hready,
  input  logic [SLAVES-1:0]                              slv_hresp
);

  // Decoder results
  logic [MASTERS-1:0][SLAVES-1:0] req_sel;
  logic [MASTERS-1:0]             can_switch;
  logic [MASTERS-1:0]             unmapped;
  // One-hot owner per slave layer
  logic [SLAVES-1:0][MASTERS-1:0] granted_master;

  ahb_addr_decoder #(
    .MASTERS (MASTERS),
    .SLAVES  (SLAVES),
    .PLEN    (PLEN)
  ) u_decoder (
    .mst_hsel      (mst_hsel),
    .mst_haddr     (mst_haddr),
    .mst_htrans    (mst_htrans),
    .mst_hmastlock (mst_hmastlock),
    .req_sel       (req_sel),
    .can_switch    (can_switch),
    .unmapped      (unmapped)
  );

  ////////////////////////////////////////////////////////////
  // One arbiter and multiplexer per slave layer
  ////////////////////////////////////////////////////////////

  genvar s, m;

  for (s = 0; s < SLAVES; s++) begin : g_slave_port
    // Column s of the request matrix
    logic [MASTERS-1:0] req_sel_col;

    for (m = 0; m < MASTERS; m++) begin : g_col
      assign req_sel_col[m] = req_sel[m][s];
    end

    ahb_slave_port #(
      .MASTERS (MASTERS),
      .PLEN    (PLEN),
      .XLEN    (XLEN)
    ) u_port (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .req_sel_col    (req_sel_col),
      .mst_priority   (mst_priority),
      .mst_haddr      (mst_haddr),
      .mst_hwdata     (mst_hwdata),
      .mst_hwrite     (mst_hwrite),
      .mst_hsize      (mst_hsize),
      .mst_hburst     (mst_hburst),
      .mst_hprot      (mst_hprot),
      .mst_htrans     (mst_htrans),
      .mst_hmastlock  (mst_hmastlock),
      .can_switch     (can_switch),
      .slv_hready     (slv_hready[s]),
      .slv_hsel       (slv_hsel[s]),
      .slv_haddr      (slv_haddr[s]),
      .slv_hwdata     (slv_hwdata[s]),
      .slv_hwrite     (slv_hwrite[s]),
      .slv_hsize      (slv_hsize[s]),
      .slv_hburst     (slv_hburst[s]),
      .slv_hprot      (slv_hprot[s]),
      .slv_htrans     (slv_htrans[s]),
      .slv_hmastlock  (slv_hmastlock[s]),
      .granted_master (granted_master[s])
    );
  end

  ahb_response_router #(
    .MASTERS (MASTERS),
    .SLAVES  (SLAVES),
    .XLEN    (XLEN)
  ) u_router (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .req_sel        (req_sel),
    .unmapped       (unmapped),
    .granted_master (granted_master),
    .slv_hrdata     (slv_hrdata),
    .slv_hready     (slv_hready),
    .slv_hresp      (slv_hresp),
    .mst_hrdata     (mst_hrdata),
    .mst_hreadyout  (mst_hreadyout),
    .mst_hresp      (mst_hresp)
  );

endmodule

// File: logic/switch_map_pkg.sv
// Switch address map
package switch_map_pkg;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // Width of a master priority, larger value wins
  localparam int prio_w      = 3;
  // Number of priority levels, one round-robin record each
  localparam int prio_levels = 2 ** prio_w;

  ////////////////////////////////////////////////////////////
  // Slave regions
  ////////////////////////////////////////////////////////////

  // Top address bits that pick a slave region
  localparam int region_bits = 2;

  // Base address of region s
  // Region index sits in the top region_bits of a plen wide address
  function automatic logic [63:0] region_base(input int unsigned s, input int unsigned plen);
    logic [63:0] base;
    base = 64'(s) << (plen - region_bits);
    return base;
  endfunction

endpackage

// File: src.f
logic/ahb_lite_pkg.sv
logic/switch_map_pkg.sv
logic/ahb_addr_decoder.sv
logic/ahb_slave_port.sv
logic/ahb_response_router.sv
logic/ahb_switch_top.sv
verif/ahb_mem_slave.sv
verif/ahb_switch_tb.sv

// File: verif/ahb_mem_slave.sv
// AHB-Lite memory slave model
module ahb_mem_slave #(
  parameter int PLEN = 32,
  parameter int XLEN = 32
) (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              hsel,
  input  logic [PLEN-1:0]                   haddr,
  input  logic [XLEN-1:0]                   hwdata,
  input  logic                              hwrite,
  input  logic [ahb_lite_pkg::htrans_w-1:0] htrans,
  output logic                              hready,
  output logic [XLEN-1:0]                   hrdata,
  output logic                              hresp
);
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_lite_pkg::*;

  // 64 words, word address bits 7:2
  logic [XLEN-1:0] mem [64];
  // Data phase state
  logic            dp_valid;
  logic            dp_write;
  logic [5:0]      dp_addr;
  logic [1:0]      wait_cnt;
  integer          seed;

  initial seed = 37;

  // Ready once the drawn wait states have run out
  assign hready = !dp_valid || (wait_cnt == 2'd0);
  assign hrdata = (dp_valid && !dp_write) ? mem[dp_addr] : '0;
  assign hresp  = hresp_okay;

  always @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_valid <= 1'b0;
      dp_write <= 1'b0;
      dp_addr  <= '0;
      wait_cnt <= '0;
    end else if (!hready) begin
      wait_cnt <= wait_cnt - 2'd1;
    end else begin
      // Write lands as the data phase completes
      if (dp_valid && dp_write) begin
        mem[dp_addr] <= hwdata;
      end
      // NONSEQ and SEQ both carry bit 1
      dp_valid <= hsel && htrans[1];
      dp_write <= hwrite;
      dp_addr  <= haddr[7:2];
      wait_cnt <= 2'($unsigned($random(seed)) % 3);
    end
  end

endmodule

// File: verif/ahb_switch_tb.sv
// AHB-Lite switch testbench
module ahb_switch_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_lite_pkg::*;
  import switch_map_pkg::*;

  localparam int MASTERS     = 3;
  localparam int SLAVES      = 3;
  localparam int PLEN        = 32;
  localparam int XLEN        = 32;
  // 12 + 16 + 5 + 8 + 3 transfers over all tests
  localparam int n_xfers     = 44;
  localparam int cycle_limit = 4 * n_xfers * 4 + 200;

  logic HCLK;
  logic HRESETn;
  logic [MASTERS-1:0]                mst_hsel, mst_hwrite, mst_hmastlock;
  logic [MASTERS-1:0][PLEN-1:0]      mst_haddr;
  logic [MASTERS-1:0][XLEN-1:0]      mst_hwdata, mst_hrdata;
  logic [MASTERS-1:0][hsize_w-1:0]   mst_hsize;
  logic [MASTERS-1:0][hburst_w-1:0]  mst_hburst;
  logic [MASTERS-1:0][hprot_w-1:0]   mst_hprot;
  logic [MASTERS-1:0][htrans_w-1:0]  mst_htrans;
  logic [MASTERS-1:0][prio_w-1:0]    mst_priority;
  logic [MASTERS-1:0]                mst_hreadyout, mst_hresp;
  logic [SLAVES-1:0]                 slv_hsel, slv_hwrite, slv_hmastlock;
  logic [SLAVES-1:0][PLEN-1:0]       slv_haddr;
  logic [SLAVES-1:0][XLEN-1:0]       slv_hwdata, slv_hrdata;
  logic [SLAVES-1:0][hsize_w-1:0]    slv_hsize;
  logic [SLAVES-1:0][hburst_w-1:0]   slv_hburst;
  logic [SLAVES-1:0][hprot_w-1:0]    slv_hprot;
  logic [SLAVES-1:0][htrans_w-1:0]   slv_htrans;
  logic [SLAVES-1:0]                 slv_hready, slv_hresp;

  // Master progress changed only off the rising edge
  logic [MASTERS-1:0]           in_addr, in_dp, chk_rd, err_xfer, exp_resp;
  logic [MASTERS-1:0][XLEN-1:0] rd_exp;
  logic [MASTERS-1:0]           done, stalled;
  // Arbitration tracking
  logic       rr_mode, prio_mode, hi_done;
  logic [1:0] waited;
  int         last_done;
  int         cycles;
  integer     seed;
  logic [XLEN-1:0] ref_mem [logic [PLEN-1:0]];

  always #50 HCLK = ~HCLK;

  ahb_switch_top #(.MASTERS(MASTERS), .SLAVES(SLAVES), .PLEN(PLEN), .XLEN(XLEN)) uut (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .mst_hsel(mst_hsel), .mst_haddr(mst_haddr), .mst_hwdata(mst_hwdata),
    .mst_hwrite(mst_hwrite), .mst_hsize(mst_hsize), .mst_hburst(mst_hburst),
    .mst_hprot(mst_hprot), .mst_htrans(mst_htrans), .mst_hmastlock(mst_hmastlock),
    .mst_priority(mst_priority), .mst_hrdata(mst_hrdata),
    .mst_hreadyout(mst_hreadyout), .mst_hresp(mst_hresp),
    .slv_hsel(slv_hsel), .slv_haddr(slv_haddr), .slv_hwdata(slv_hwdata),
    .slv_hwrite(slv_hwrite), .slv_hsize(slv_hsize), .slv_hburst(slv_hburst),
    .slv_hprot(slv_hprot), .slv_htrans(slv_htrans), .slv_hmastlock(slv_hmastlock),
    .slv_hrdata(slv_hrdata), .slv_hready(slv_hready), .slv_hresp(slv_hresp)
  );

  for (genvar s = 0; s < SLAVES; s++) begin : g_mem
    ahb_mem_slave #(.PLEN(PLEN), .XLEN(XLEN)) u_mem (
      .HCLK(HCLK), .HRESETn(HRESETn), .hsel(slv_hsel[s]), .haddr(slv_haddr[s]),
      .hwdata(slv_hwdata[s]), .hwrite(slv_hwrite[s]), .htrans(slv_htrans[s]),
      .hready(slv_hready[s]), .hrdata(slv_hrdata[s]), .hresp(slv_hresp[s])
    );
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  assign done    = in_dp & mst_hreadyout;
  assign stalled = in_addr & ~mst_hreadyout;

  // With nothing in flight every master sees ready OKAY and no slave is selected
  a_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!(|in_addr) && !(|in_dp)) |->
      ((&mst_hreadyout) && (mst_hresp == '0) && (slv_hsel == '0)))
  else begin
    $display("FAILED %0t idle mst_hreadyout/mst_hresp/slv_hsel expected %b/%b/%b actual %b/%b/%b",
             $time, {MASTERS{1'b1}}, {MASTERS{1'b0}}, {SLAVES{1'b0}},
             $sampled(mst_hreadyout), $sampled(mst_hresp), $sampled(slv_hsel));
    $display("test failed");
    $fatal(1);
  end

  // Every single transfer carries word size, no burst, data access and no lock
  for (genvar c = 0; c < SLAVES; c++) begin : g_ctrl
    a_ctrl: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (slv_hsel[c] && (slv_htrans[c] != htrans_idle)) |->
        ((slv_hsize[c] == hsize_w'(2)) && (slv_hburst[c] == '0) &&
         (slv_hprot[c] == hprot_w'(3)) && !slv_hmastlock[c]))
    else begin
      $display(
        "FAILED %0t slv_hsize,hburst,hprot,hmastlock[%0d] expected 2,0,3,0 actual %0d,%0d,%0d,%b",
        $time, c, $sampled(slv_hsize[c]), $sampled(slv_hburst[c]), $sampled(slv_hprot[c]),
        $sampled(slv_hmastlock[c]));
      $display("test failed");
      $fatal(1);
    end
  end

  for (genvar g = 0; g < MASTERS; g++) begin : g_chk
    a_rdata: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (done[g] && chk_rd[g]) |-> (mst_hrdata[g] == rd_exp[g]))
    else begin
      $display("FAILED %0t mst_hrdata[%0d] expected %h actual %h",
               $time, g, $sampled(rd_exp[g]), $sampled(mst_hrdata[g]));
      $display("test failed");
      $fatal(1);
    end

    a_resp: assert property (@(posedge HCLK) disable iff (!HRESETn)
      done[g] |-> (mst_hresp[g] == exp_resp[g]))
    else begin
      $display("FAILED %0t mst_hresp[%0d] expected %b actual %b",
               $time, g, $sampled(exp_resp[g]), $sampled(mst_hresp[g]));
      $display("test failed");
      $fatal(1);
    end

    // ERROR takes ready low for one cycle and then high
    a_err_low: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (in_addr[g] && err_xfer[g] && mst_hreadyout[g]) |=> !mst_hreadyout[g])
    else begin
      $display("FAILED %0t mst_hreadyout[%0d] expected 0 actual %b",
               $time, g, $sampled(mst_hreadyout[g]));
      $display("test failed");
      $fatal(1);
    end

    a_err_high: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (in_addr[g] && err_xfer[g] && mst_hreadyout[g]) |=> ##1 mst_hreadyout[g])
    else begin
      $display("FAILED %0t mst_hreadyout[%0d] expected 1 actual %b",
               $time, g, $sampled(mst_hreadyout[g]));
      $display("test failed");
      $fatal(1);
    end
  end

  for (genvar r = 0; r < 2; r++) begin : g_rr
    a_rr: assert property (@(posedge HCLK) disable iff (!HRESETn)
      !(rr_mode && done[r] && (last_done == r) && waited[1-r]))
    else begin
      $display("round-robin broken at %0t: master %0d completed twice while master %0d waited",
               $time, r, 1 - r);
      $display("test failed");
      $fatal(1);
    end
  end

  a_prio: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(prio_mode && done[2] && !hi_done))
  else begin
    $display("priority broken at %0t: low priority master 2 finished before master 1", $time);
    $display("test failed");
    $fatal(1);
  end

  // Completion order of the contending masters
  always @(posedge HCLK) begin
    if (!rr_mode) begin
      last_done <= -1;
      waited    <= '0;
    end else begin
      if (done[0]) last_done <= 0;
      else if (done[1]) last_done <= 1;
      for (int o = 0; o < 2; o++) begin
        if (stalled[o]) waited[o] <= 1'b1;
        else if (done[0] || done[1]) waited[o] <= 1'b0;
      end
    end
    hi_done <= prio_mode && (hi_done || done[1]);
  end

  // Hang guard
  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run hung, no end after %0d cycles", cycles);
      $display("test failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic logic is_mapped(input logic [PLEN-1:0] a);
    logic [63:0] b;
    logic        hit;
    hit = 1'b0;
    for (int s = 0; s < SLAVES; s++) begin
      b = region_base(s, PLEN);
      if (a[PLEN-1 -: region_bits] == b[PLEN-1 -: region_bits]) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic logic [PLEN-1:0] base_of(input int s);
    logic [63:0] b;
    b = region_base(s, PLEN);
    return b[PLEN-1:0];
  endfunction

  // One single transfer of master m through address and data phase
  task automatic single_xfer(input int m, input logic [PLEN-1:0] a, input logic wr,
                             input logic [XLEN-1:0] wd);
    logic mapped;
    mapped = is_mapped(a);
    @(negedge HCLK);
    mst_hsel[m]   = 1'b1;
    mst_haddr[m]  = a;
    mst_hwrite[m] = wr;
    mst_hsize[m]  = hsize_w'(2);
    mst_hburst[m] = '0;
    mst_hprot[m]  = hprot_w'(3);
    mst_htrans[m] = htrans_nonseq;
    in_addr[m]    = 1'b1;
    err_xfer[m]   = !mapped;
    #1;
    while (!mst_hreadyout[m]) begin
      @(negedge HCLK);
      #1;
    end
    // Address taken at the coming edge
    @(negedge HCLK);
    mst_hsel[m]   = 1'b0;
    mst_htrans[m] = htrans_idle;
    mst_hwdata[m] = wr ? wd : '0;
    in_addr[m]    = 1'b0;
    in_dp[m]      = 1'b1;
    exp_resp[m]   = mapped ? hresp_okay : hresp_error;
    chk_rd[m]     = !wr && mapped;
    if (!wr && mapped) rd_exp[m] = ref_mem[a];
    #1;
    while (!mst_hreadyout[m]) begin
      @(negedge HCLK);
      #1;
    end
    if (wr && mapped) ref_mem[a] = wd;
    @(posedge HCLK);
    #1;
    in_dp[m]    = 1'b0;
    chk_rd[m]   = 1'b0;
    err_xfer[m] = 1'b0;
  endtask

  // Writes of n words from a followed by reads of the same words
  task automatic write_read_run(input int m, input logic [PLEN-1:0] a, input int n);
    for (int i = 0; i < n; i++) single_xfer(m, a + 4 * i, 1'b1, $random(seed));
    for (int i = 0; i < n; i++) single_xfer(m, a + 4 * i, 1'b0, '0);
  endtask

  initial begin
    HCLK = 1'b0;
    HRESETn = 1'b0;
    mst_hsel = '0;
    mst_haddr = '0;
    mst_hwdata = '0;
    mst_hwrite = '0;
    mst_hsize = '0;
    mst_hburst = '0;
    mst_hprot = '0;
    mst_htrans = '0;
    mst_hmastlock = '0;
    mst_priority = '0;
    in_addr = '0;
    in_dp = '0;
    chk_rd = '0;
    err_xfer = '0;
    exp_resp = '0;
    rd_exp = '0;
    rr_mode = 1'b0;
    prio_mode = 1'b0;
    cycles = 0;
    seed = 37;
    repeat (8) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    repeat (2) @(negedge HCLK);

    // One master on every mapped region
    for (int s = 0; s < SLAVES; s++) begin
      for (int i = 0; i < 2; i++) begin
        single_xfer(0, base_of(s) + 32'h10 + 4 * i, 1'b1, $random(seed));
        single_xfer(0, base_of(s) + 32'h10 + 4 * i, 1'b0, '0);
      end
    end

    // Equal priority contention on slave 2
    @(negedge HCLK);
    mst_priority = {MASTERS{prio_w'(2)}};
    rr_mode = 1'b1;
    fork
      write_read_run(0, base_of(2) + 32'h40, 4);
      write_read_run(1, base_of(2) + 32'h80, 4);
    join
    @(negedge HCLK);
    rr_mode = 1'b0;

    // Master 1 above master 2 on idle slave 1 in a write round and a read round
    mst_priority[1] = prio_w'(5);
    mst_priority[2] = prio_w'(1);
    for (int k = 0; k < 2; k++) begin
      // Slave 1 grant parks on master 0 so neither contender holds it
      if (k == 1) begin
        single_xfer(0, base_of(1) + 32'h30, 1'b0, '0);
      end
      @(negedge HCLK);
      prio_mode = 1'b1;
      fork
        single_xfer(1, base_of(1) + 32'h30, (k == 0), $random(seed));
        single_xfer(2, base_of(1) + 32'h34, (k == 0), $random(seed));
      join
      @(negedge HCLK);
      prio_mode = 1'b0;
      @(negedge HCLK);
    end

    // Parallel traffic on separate layers
    mst_priority = {MASTERS{prio_w'(2)}};
    fork
      write_read_run(0, base_of(0) + 32'h60, 2);
      write_read_run(2, base_of(1) + 32'h60, 2);
    join

    // Region 3 is unmapped and slave 0 must still hold its old word
    single_xfer(1, 32'hC000_0010, 1'b1, 32'hDEAD_BEEF);
    single_xfer(1, 32'hC000_0010, 1'b0, '0);
    single_xfer(1, base_of(0) + 32'h10, 1'b0, '0);

    repeat (2) @(negedge HCLK);
    $display("test passed");
    $finish;
  end

endmodule
